// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module mem_system_tb \
   -f verilog.f \
   -Mdir obj_dir -o mem_system_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output="$(./obj_dir/mem_system_sim 2>&1)"
run_status=$?
printf '%s\n' "$output"
if [ $run_status -ne 0 ]; then
   echo "Simulation exited with status $run_status"
   exit 1
fi

if grep -qF '*** TEST PASSED ***' <<< "$output"; then
   exit 0
fi
exit 1

// File: verif/mem_system_assertions.sv
`default_nettype none

module mem_system_assertions (
   input logic                           clk,
   input logic                           rst_n,
   input logic [mem_sys_pkg::addr_w-1:0] addr,
   input logic                           rd,
   input logic                           wr,
   input mem_sys_pkg::ctrl_state_e       state,
   input mem_sys_pkg::mem_cmd_t          mem_cmd,
   input mem_sys_pkg::mem_rsp_t          mem_rsp,
   input logic                           done,
   input logic                           stall,
   input logic                           err
);

   timeunit 1ns;
   timeprecision 100ps;

   // Request accepted and not yet completed
   logic req_open;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         req_open <= 1'b0;
      end else if (done) begin
         req_open <= 1'b0;
      end else if (!stall && (rd || wr)) begin
         req_open <= 1'b1;
      end
   end

   ////////////////////////////////////////////////////////////////////
   // Processor handshake
   ////////////////////////////////////////////////////////////////////

   done_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      done |=> !done) else $error("done held for more than one cycle");

   // Ready only once the open request has completed
   stall_low_free: assert property (@(posedge clk) disable iff (!rst_n)
      !stall |-> (!done && !req_open))
      else $error("stall low while a request is in progress");

   // Odd address or both strobes ends at once
   illegal_gets_err: assert property (@(posedge clk) disable iff (!rst_n)
      (!stall && (rd || wr) && (addr[0] || (rd && wr))) |=> (err && done))
      else $error("illegal request did not end with err and done");

   ////////////////////////////////////////////////////////////////////
   // Memory command
   ////////////////////////////////////////////////////////////////////

   // A refused command waits unchanged for its bank
   cmd_held: assert property (@(posedge clk) disable iff (!rst_n)
      (mem_cmd.op != mem_sys_pkg::op_none && mem_rsp.stall) |=>
         (mem_cmd.op == $past(mem_cmd.op) && mem_cmd.addr == $past(mem_cmd.addr)))
      else $error("memory command changed while stalled");

endmodule

bind cache_ctrl mem_system_assertions u_assert (
   .clk     (clk),
   .rst_n   (rst_n),
   .addr    (addr),
   .rd      (rd),
   .wr      (wr),
   .state   (state),
   .mem_cmd (mem_cmd),
   .mem_rsp (mem_rsp),
   .done    (done),
   .stall   (stall),
   .err     (err)
);

`default_nettype wire

// File: verif/mem_system_tb.sv
`default_nettype none

module mem_system_tb;

   timeunit 1ns;
   timeprecision 100ps;

   logic        clk;
   logic        rst_n;
   logic [15:0] addr;
   logic [15:0] wdata;
   logic        rd;
   logic        wr;
   logic [15:0] rdata;
   logic        done;
   logic        stall;
   logic        cache_hit;
   logic        err;

   // Reference model of flat word memory plus per-index line state
   logic [15:0] ref_mem [32768];
   logic [4:0]  ref_tag [256];
   logic        ref_valid [256];
   logic        ref_dirty [256];

   // Result of the last request
   logic [15:0] obs_rdata;
   logic        obs_hit;
   logic        obs_err;
   int          obs_lat;

   logic [15:0] lfsr_state;
   logic        timed_out;
   int          checks;
   int          errors;
   int          evictions;

   mem_system i_dut (
      .clk       (clk),
      .rst_n     (rst_n),
      .addr      (addr),
      .wdata     (wdata),
      .rd        (rd),
      .wr        (wr),
      .rdata     (rdata),
      .done      (done),
      .stall     (stall),
      .cache_hit (cache_hit),
      .err       (err)
   );

   always #4 clk = ~clk;

   //////////////////////////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////////////////////////

   // 16-bit Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] v;
      logic        fb;
      v = '0;
      for (int k = 0; k < n; k++) begin
         fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
         lfsr_state = {lfsr_state[14:0], fb};
         v = {v[14:0], lfsr_state[0]};
      end
      return v;
   endfunction

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      checks++;
      if (got !== exp) begin
         $display("CHECK FAILED %s got 0x%04h expected 0x%04h at %0t", name, got, exp, $time);
         errors++;
      end
   endtask

   // One processor request from stall low to done
   task automatic run_request(input logic do_rd, input logic do_wr,
                              input logic [15:0] a, input logic [15:0] d);
      int cnt;
      cnt = 0;
      if (timed_out) return;
      while (stall && cnt < 200) begin
         @(posedge clk);
         #1;
         cnt++;
      end
      if (stall) begin
         $display("Timeout: stall never fell before a new request");
         timed_out = 1'b1;
         errors++;
         return;
      end
      addr  = a;
      wdata = d;
      rd    = do_rd;
      wr    = do_wr;
      cnt   = 0;
      // First sample still falls before the accepting edge
      @(negedge clk);
      while (!done && cnt < 200) begin
         @(negedge clk);
         cnt++;
      end
      if (!done) begin
         $display("Timeout: done never rose for address 0x%04h", a);
         timed_out = 1'b1;
         errors++;
         return;
      end
      obs_rdata = rdata;
      obs_hit   = cache_hit;
      obs_err   = err;
      obs_lat   = cnt;
      @(posedge clk);
      #1;
      rd = 1'b0;
      wr = 1'b0;
   endtask

   // Check one request against the model and update the model afterwards
   task automatic checked_access(input logic do_rd, input logic do_wr,
                                 input logic [15:0] a, input logic [15:0] d);
      logic        exp_err;
      logic        exp_hit;
      logic [7:0]  idx;
      logic [4:0]  tg;
      logic [14:0] wa;
      exp_err = a[0] | (do_rd & do_wr);
      idx     = a[10:3];
      tg      = a[15:11];
      wa      = a[15:1];
      exp_hit = !exp_err && ref_valid[idx] && (ref_tag[idx] == tg);
      run_request(do_rd, do_wr, a, d);
      if (timed_out) return;
      check_value("err", {15'b0, obs_err}, {15'b0, exp_err});
      check_value("cache_hit", {15'b0, obs_hit}, {15'b0, exp_hit});
      if (!exp_err && do_rd) check_value("rdata", obs_rdata, ref_mem[wa]);
      if (!exp_err) begin
         if (!exp_hit) begin
            if (ref_valid[idx] && ref_dirty[idx]) evictions++;
            // Refilled line starts clean
            ref_dirty[idx] = 1'b0;
         end
         ref_valid[idx] = 1'b1;
         ref_tag[idx]   = tg;
         if (do_wr) begin
            ref_mem[wa]    = d;
            ref_dirty[idx] = 1'b1;
         end
      end
   endtask

   task automatic report_test(input string name, input int errs_before);
      if (timed_out) $display("test %s: stopped by a timeout", name);
      else if (errors == errs_before) $display("test %s: ok", name);
      else $display("test %s: %0d errors", name, errors - errs_before);
   endtask

   //////////////////////////////////////////////////////////////////////
   // Sequence
   //////////////////////////////////////////////////////////////////////

   initial begin
      logic [15:0] r_tag;
      logic [15:0] r_idx;
      logic [15:0] r_word;
      logic [15:0] r_op;
      logic [15:0] r_data;
      logic [15:0] a;
      int          errs_before;
      clk        = 1'b0;
      rst_n      = 1'b0;
      addr       = '0;
      wdata      = '0;
      rd         = 1'b0;
      wr         = 1'b0;
      lfsr_state = 16'd60620;
      timed_out  = 1'b0;
      checks     = 0;
      errors     = 0;
      evictions  = 0;
      for (int k = 0; k < 32768; k++) ref_mem[k] = '0;
      for (int k = 0; k < 256; k++) begin
         ref_tag[k]   = '0;
         ref_valid[k] = 1'b0;
         ref_dirty[k] = 1'b0;
      end
      repeat (3) @(posedge clk);
      #1;
      rst_n = 1'b1;

      // Quiet outputs and a cold read of zeroed memory
      errs_before = errors;
      check_value("stall", {15'b0, stall}, 16'h0);
      check_value("done", {15'b0, done}, 16'h0);
      check_value("err", {15'b0, err}, 16'h0);
      checked_access(1'b1, 1'b0, 16'h1a2c, 16'h0);
      report_test("reset_and_cold_read", errs_before);

      // Write miss followed by a one-cycle read hit
      errs_before = errors;
      a = {5'd9, 8'h05, 2'd3, 1'b0};
      checked_access(1'b0, 1'b1, a, 16'h5a5a);
      checked_access(1'b1, 1'b0, a, 16'h0);
      if (!timed_out) check_value("latency", 16'(obs_lat), 16'd1);
      report_test("write_then_read_hit", errs_before);

      // Few indexes and all tags give frequent conflicts
      errs_before = errors;
      for (int i = 0; i < 300; i++) begin
         r_tag  = rand_bits(5);
         r_idx  = rand_bits(2);
         r_word = rand_bits(2);
         r_op   = rand_bits(1);
         r_data = rand_bits(16);
         a = {r_tag[4:0], 6'b010000, r_idx[1:0], r_word[1:0], 1'b0};
         checked_access(r_op[0], ~r_op[0], a, r_data);
      end
      report_test($sformatf("random_300 (%0d dirty evictions)", evictions), errs_before);

      // Two tags fight for index 0x91
      errs_before = errors;
      checked_access(1'b0, 1'b1, {5'd3, 8'h91, 2'd1, 1'b0}, 16'h1234);
      checked_access(1'b0, 1'b1, {5'd12, 8'h91, 2'd1, 1'b0}, 16'hbeef);
      checked_access(1'b1, 1'b0, {5'd3, 8'h91, 2'd1, 1'b0}, 16'h0);
      checked_access(1'b1, 1'b0, {5'd12, 8'h91, 2'd1, 1'b0}, 16'h0);
      report_test("dirty_eviction", errs_before);

      // Illegal requests leave data alone
      errs_before = errors;
      a = {5'd7, 8'h22, 2'd2, 1'b0};
      checked_access(1'b0, 1'b1, a, 16'h2468);
      checked_access(1'b0, 1'b1, a | 16'h1, 16'hdead);
      if (!timed_out) check_value("latency", 16'(obs_lat), 16'd1);
      checked_access(1'b1, 1'b1, a, 16'hfeed);
      checked_access(1'b1, 1'b0, a | 16'h1, 16'h0);
      checked_access(1'b1, 1'b0, a, 16'h0);
      report_test("illegal_requests", errs_before);

      $display("checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: verilog.f
verilog/mem_sys_pkg.sv
verilog/cache_array.sv
verilog/cache_ctrl.sv
verilog/banked_mem.sv
verilog/mem_system.sv
verif/mem_system_assertions.sv
verif/mem_system_tb.sv

// File: verilog/banked_mem.sv
`default_nettype none

module banked_mem (
   input  logic                  clk,
   input  logic                  rst_n,
   input  mem_sys_pkg::mem_cmd_t mem_cmd,
   output mem_sys_pkg::mem_rsp_t mem_rsp
);

   // Low word address bits pick the bank
   logic [1:0]                       bank_sel;
   logic [mem_sys_pkg::addr_w-4:0]   bank_addr;
   logic                             take;
   logic                             rd_take;
   logic [3:0]                       busy;
   logic [mem_sys_pkg::data_w-1:0]   bank_q [4];
   logic [1:0]                       rd_bank_q;
   logic [mem_sys_pkg::data_w-1:0]   rd_pipe [mem_sys_pkg::mem_rd_latency-1];

   assign bank_sel  = mem_cmd.addr[1:0];
   assign bank_addr = mem_cmd.addr[mem_sys_pkg::addr_w-2:2];

   // Busy bank refuses the command
   assign take    = (mem_cmd.op != mem_sys_pkg::op_none) & ~busy[bank_sel];
   assign rd_take = take & (mem_cmd.op == mem_sys_pkg::op_read);

   //////////////////////////////////////////////////////////////////////
   // Banks
   //////////////////////////////////////////////////////////////////////

   for (genvar b = 0; b < 4; b++) begin : g_bank
      logic [mem_sys_pkg::data_w-1:0] mem [2**(mem_sys_pkg::addr_w-3)];
      logic [mem_sys_pkg::data_w-1:0] rd_q;
      logic [$clog2(mem_sys_pkg::bank_busy_cycles+1)-1:0] busy_cnt;
      logic                                               sel;

      assign sel = take & (bank_sel == 2'(b));

      // Power-up contents, reset leaves them alone
      initial begin
         for (int i = 0; i < 2**(mem_sys_pkg::addr_w-3); i++) begin
            mem[i] = '0;
         end
      end

      // Reload on every access, count down to free
      always_ff @(posedge clk or negedge rst_n) begin
         if (!rst_n) begin
            busy_cnt <= '0;
         end else if (sel) begin
            busy_cnt <= $bits(busy_cnt)'(mem_sys_pkg::bank_busy_cycles);
         end else if (busy_cnt != '0) begin
            busy_cnt <= busy_cnt - 1'b1;
         end
      end

      // Write lands at the taking edge, read is registered
      always_ff @(posedge clk) begin
         if (sel && mem_cmd.op == mem_sys_pkg::op_write) begin
            mem[bank_addr] <= mem_cmd.wdata;
         end
         if (sel && mem_cmd.op == mem_sys_pkg::op_read) begin
            rd_q <= mem[bank_addr];
         end
      end

      assign busy[b]   = (busy_cnt != '0);
      assign bank_q[b] = rd_q;
   end

   //////////////////////////////////////////////////////////////////////
   // Read return
   //////////////////////////////////////////////////////////////////////

   // Which bank holds the word read last cycle
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) rd_bank_q <= '0;
      else if (rd_take) rd_bank_q <= bank_sel;
   end

   always_ff @(posedge clk) begin
      rd_pipe[0] <= bank_q[rd_bank_q];
      for (int s = 1; s < mem_sys_pkg::mem_rd_latency-1; s++) begin
         rd_pipe[s] <= rd_pipe[s-1];
      end
   end

   assign mem_rsp.rdata = rd_pipe[mem_sys_pkg::mem_rd_latency-2];
   assign mem_rsp.stall = (mem_cmd.op != mem_sys_pkg::op_none) & busy[bank_sel];
   assign mem_rsp.busy  = busy;

endmodule

`default_nettype wire

// File: verilog/cache_array.sv
`default_nettype none

module cache_array (
   input  logic                     clk,
   input  logic                     rst_n,
   input  mem_sys_pkg::cache_cmd_t  cache_cmd,
   output mem_sys_pkg::cache_stat_t cache_stat
);

   //////////////////////////////////////////////////////////////////////
   // Storage
   //////////////////////////////////////////////////////////////////////

   // One tag per line
   logic [mem_sys_pkg::tag_w-1:0] tag_mem [2**mem_sys_pkg::index_w];

   // Line state bits, flat vectors so reset can clear them
   logic [2**mem_sys_pkg::index_w-1:0] valid_q;
   logic [2**mem_sys_pkg::index_w-1:0] dirty_q;

   // Data words addressed by {index, word}
   logic [mem_sys_pkg::data_w-1:0]
      data_mem [2**mem_sys_pkg::index_w * mem_sys_pkg::words_per_line];

   logic [mem_sys_pkg::index_w+1:0] word_idx;
   logic                            line_valid;
   logic                            tag_match;
   logic                            comp_hit;
   logic                            comp_wr;
   logic                            acc_wr;
   logic                            line_install;

   //////////////////////////////////////////////////////////////////////
   // Lookup
   //////////////////////////////////////////////////////////////////////

   assign word_idx   = {cache_cmd.index, cache_cmd.word};
   assign line_valid = valid_q[cache_cmd.index];
   assign tag_match  = (tag_mem[cache_cmd.index] == cache_cmd.tag);

   // Hit only means something in compare mode
   assign comp_hit = cache_cmd.enable & cache_cmd.comp & line_valid & tag_match;

   assign cache_stat.hit     = comp_hit;
   assign cache_stat.dirty   = dirty_q[cache_cmd.index];
   assign cache_stat.valid   = line_valid;
   assign cache_stat.tag_out = tag_mem[cache_cmd.index];
   assign cache_stat.rdata   = data_mem[word_idx];

   // Compare write lands only on a hit
   assign comp_wr = comp_hit & cache_cmd.write;

   // Access write skips the tag check
   assign acc_wr = cache_cmd.enable & ~cache_cmd.comp & cache_cmd.write;

   // Last fill word installs the new tag
   assign line_install = acc_wr & cache_cmd.valid_in;

   //////////////////////////////////////////////////////////////////////
   // Update
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         valid_q <= '0;
         dirty_q <= '0;
      end else if (line_install) begin
         // Fresh line from memory is clean
         valid_q[cache_cmd.index] <= 1'b1;
         dirty_q[cache_cmd.index] <= 1'b0;
      end else if (comp_wr) begin
         dirty_q[cache_cmd.index] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (comp_wr || acc_wr) begin
         data_mem[word_idx] <= cache_cmd.wdata;
      end
      if (line_install) begin
         tag_mem[cache_cmd.index] <= cache_cmd.tag;
      end
   end

endmodule

`default_nettype wire

// File: verilog/cache_ctrl.sv
`default_nettype none

module cache_ctrl (
   input  logic                                clk,
   input  logic                                rst_n,
   input  logic [mem_sys_pkg::addr_w-1:0]      addr,
   input  logic [mem_sys_pkg::data_w-1:0]      wdata,
   input  logic                                rd,
   input  logic                                wr,
   output mem_sys_pkg::cache_cmd_t             cache_cmd,
   input  mem_sys_pkg::cache_stat_t            cache_stat,
   output mem_sys_pkg::mem_cmd_t               mem_cmd,
   input  mem_sys_pkg::mem_rsp_t               mem_rsp,
   output logic [mem_sys_pkg::data_w-1:0]      rdata,
   output logic                                done,
   output logic                                stall,
   output logic                                cache_hit,
   output logic                                err
);

   mem_sys_pkg::ctrl_state_e state;
   mem_sys_pkg::ctrl_state_e next_state;

   // Captured request
   mem_sys_pkg::req_op_e             req_op;
   logic [mem_sys_pkg::tag_w-1:0]    req_tag;
   logic [mem_sys_pkg::index_w-1:0]  req_index;
   logic [1:0]                       req_word;
   logic [mem_sys_pkg::data_w-1:0]   req_wdata;

   // Words sent to memory, and fill words written back into the array
   logic [2:0] word_cnt;
   logic [2:0] rcv_cnt;

   logic mem_take;
   logic ld_take;
   logic ld_arrive;

   // Loads in flight, one slot per cycle of memory latency
   logic [mem_sys_pkg::mem_rd_latency-1:0] ld_vld;
   logic [1:0]                             ld_word [mem_sys_pkg::mem_rd_latency];

   //////////////////////////////////////////////////////////////////////
   // Request capture
   //////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (state == mem_sys_pkg::st_idle && (rd || wr)) begin
         req_tag   <= addr[mem_sys_pkg::addr_w-1 -: mem_sys_pkg::tag_w];
         req_index <= addr[mem_sys_pkg::addr_w-1-mem_sys_pkg::tag_w -: mem_sys_pkg::index_w];
         req_word  <= addr[2:1];
         req_wdata <= wdata;
      end
   end

   //////////////////////////////////////////////////////////////////////
   // State, counters, load tracking
   //////////////////////////////////////////////////////////////////////

   // Memory took this cycle's command
   assign mem_take  = (mem_cmd.op != mem_sys_pkg::op_none) & ~mem_rsp.stall;
   assign ld_take   = mem_take & (mem_cmd.op == mem_sys_pkg::op_read);
   assign ld_arrive = ld_vld[mem_sys_pkg::mem_rd_latency-1];

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= mem_sys_pkg::st_idle;
         req_op   <= mem_sys_pkg::op_none;
         word_cnt <= '0;
         rcv_cnt  <= '0;
         ld_vld   <= '0;
      end else begin
         state  <= next_state;
         ld_vld <= {ld_vld[mem_sys_pkg::mem_rd_latency-2:0], ld_take};
         if (state == mem_sys_pkg::st_idle && (rd || wr)) begin
            req_op <= rd ? mem_sys_pkg::op_read : mem_sys_pkg::op_write;
         end
         // Counters restart on every compare
         if (state == mem_sys_pkg::st_compare) begin
            word_cnt <= '0;
            rcv_cnt  <= '0;
         end else begin
            // Stall freezes the counter; writeback hands a fresh count to the fill
            if (mem_take) begin
               if (state == mem_sys_pkg::st_writeback &&
                   word_cnt == 3'(mem_sys_pkg::words_per_line - 1)) begin
                  word_cnt <= '0;
               end else begin
                  word_cnt <= word_cnt + 3'd1;
               end
            end
            if (ld_arrive) rcv_cnt <= rcv_cnt + 3'd1;
         end
      end
   end

   // Word offset of each load follows it down the pipe
   always_ff @(posedge clk) begin
      ld_word[0] <= word_cnt[1:0];
      for (int s = 1; s < mem_sys_pkg::mem_rd_latency; s++) begin
         ld_word[s] <= ld_word[s-1];
      end
   end

   //////////////////////////////////////////////////////////////////////
   // FSM
   //////////////////////////////////////////////////////////////////////

   always_comb begin
      next_state = state;
      cache_cmd  = '0;
      mem_cmd    = '0;
      // Most states address the requested word
      cache_cmd.tag   = req_tag;
      cache_cmd.index = req_index;
      cache_cmd.word  = req_word;
      cache_cmd.wdata = req_wdata;
      mem_cmd.addr    = {req_tag, req_index, word_cnt[1:0]};
      mem_cmd.wdata   = cache_stat.rdata;
      case (state)
         mem_sys_pkg::st_idle: begin
            // Odd address or both strobes is refused
            if (rd || wr) begin
               next_state = (addr[0] || (rd && wr)) ? mem_sys_pkg::st_error
                                                    : mem_sys_pkg::st_compare;
            end
         end
         mem_sys_pkg::st_compare: begin
            cache_cmd.enable = 1'b1;
            cache_cmd.comp   = 1'b1;
            cache_cmd.write  = (req_op == mem_sys_pkg::op_write);
            if (cache_stat.hit) begin
               next_state = mem_sys_pkg::st_idle;
            end else if (cache_stat.valid && cache_stat.dirty) begin
               next_state = mem_sys_pkg::st_writeback;
            end else begin
               next_state = mem_sys_pkg::st_fill;
            end
         end
         mem_sys_pkg::st_writeback: begin
            // Victim words go out under the stored tag
            cache_cmd.enable = 1'b1;
            cache_cmd.word   = word_cnt[1:0];
            mem_cmd.op       = mem_sys_pkg::op_write;
            mem_cmd.addr     = {cache_stat.tag_out, req_index, word_cnt[1:0]};
            if (mem_take && word_cnt == 3'(mem_sys_pkg::words_per_line - 1)) begin
               next_state = mem_sys_pkg::st_fill;
            end
         end
         mem_sys_pkg::st_fill: begin
            if (word_cnt < 3'(mem_sys_pkg::words_per_line)) begin
               mem_cmd.op = mem_sys_pkg::op_read;
            end
            // Arriving word goes straight into the array
            if (ld_arrive) begin
               cache_cmd.enable = 1'b1;
               cache_cmd.write  = 1'b1;
               cache_cmd.word   = ld_word[mem_sys_pkg::mem_rd_latency-1];
               cache_cmd.wdata  = mem_rsp.rdata;
               // Last word marks the line valid under the new tag
               cache_cmd.valid_in = (rcv_cnt == 3'(mem_sys_pkg::words_per_line - 1));
               if (cache_cmd.valid_in) next_state = mem_sys_pkg::st_finish;
            end
         end
         mem_sys_pkg::st_finish: begin
            // Compare again; a write now hits and sets dirty
            cache_cmd.enable = 1'b1;
            cache_cmd.comp   = 1'b1;
            cache_cmd.write  = (req_op == mem_sys_pkg::op_write);
            next_state       = mem_sys_pkg::st_idle;
         end
         mem_sys_pkg::st_error: next_state = mem_sys_pkg::st_idle;
         default: next_state = mem_sys_pkg::st_idle;
      endcase
   end

   //////////////////////////////////////////////////////////////////////
   // Processor outputs
   //////////////////////////////////////////////////////////////////////

   assign stall     = (state != mem_sys_pkg::st_idle);
   assign err       = (state == mem_sys_pkg::st_error);
   // hit is only raised in compare mode
   assign cache_hit = (state == mem_sys_pkg::st_compare) & cache_stat.hit;
   assign done      = cache_hit | err | (state == mem_sys_pkg::st_finish);
   assign rdata     = cache_stat.rdata;

endmodule

`default_nettype wire

// File: verilog/mem_sys_pkg.sv
`default_nettype none

package mem_sys_pkg;

   //////////////////////////////////////////////////////////////////////
   // Sizes
   //////////////////////////////////////////////////////////////////////

   // Processor byte address and data word
   localparam int addr_w = 16;
   localparam int data_w = 16;

   // Address split is tag, index, word offset, byte bit
   localparam int tag_w   = 5;
   localparam int index_w = 8;
   localparam int words_per_line = 4;

   // Main memory timing
   localparam int mem_rd_latency   = 2;
   localparam int bank_busy_cycles = 4;

   //////////////////////////////////////////////////////////////////////
   // Encodings
   //////////////////////////////////////////////////////////////////////

   typedef enum logic [2:0] {
      st_idle,
      st_compare,
      st_writeback,
      st_fill,
      st_finish,
      st_error
   } ctrl_state_e;

   // Also used as the memory command opcode
   typedef enum logic [1:0] {
      op_none,
      op_read,
      op_write
   } req_op_e;

   //////////////////////////////////////////////////////////////////////
   // Bundles between blocks
   //////////////////////////////////////////////////////////////////////

   // Controller to cache array
   typedef struct packed {
      logic               enable;
      logic               comp;
      logic               write;
      logic               valid_in;
      logic [tag_w-1:0]   tag;
      logic [index_w-1:0] index;
      logic [1:0]         word;
      logic [data_w-1:0]  wdata;
   } cache_cmd_t;

   // Cache array back to controller, all combinational
   typedef struct packed {
      logic              hit;
      logic              dirty;
      logic              valid;
      logic [tag_w-1:0]  tag_out;
      logic [data_w-1:0] rdata;
   } cache_stat_t;

   // Word address, so the byte bit is gone
   typedef struct packed {
      req_op_e           op;
      logic [addr_w-2:0] addr;
      logic [data_w-1:0] wdata;
   } mem_cmd_t;

   typedef struct packed {
      logic [data_w-1:0] rdata;
      logic              stall;
      logic [3:0]        busy;
   } mem_rsp_t;

endpackage

`default_nettype wire

// File: verilog/mem_system.sv
`default_nettype none

module mem_system (
   input  logic                           clk,
   input  logic                           rst_n,
   input  logic [mem_sys_pkg::addr_w-1:0] addr,
   input  logic [mem_sys_pkg::data_w-1:0] wdata,
   input  logic                           rd,
   input  logic                           wr,
   output logic [mem_sys_pkg::data_w-1:0] rdata,
   output logic                           done,
   output logic                           stall,
   output logic                           cache_hit,
   output logic                           err
);

   // Controller to array and memory
   mem_sys_pkg::cache_cmd_t  cache_cmd;
   mem_sys_pkg::cache_stat_t cache_stat;
   mem_sys_pkg::mem_cmd_t    mem_cmd;
   mem_sys_pkg::mem_rsp_t    mem_rsp;

   //////////////////////////////////////////////////////////////////////
   // Blocks
   //////////////////////////////////////////////////////////////////////

   cache_ctrl u_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .addr       (addr),
      .wdata      (wdata),
      .rd         (rd),
      .wr         (wr),
      .cache_cmd  (cache_cmd),
      .cache_stat (cache_stat),
      .mem_cmd    (mem_cmd),
      .mem_rsp    (mem_rsp),
      .rdata      (rdata),
      .done       (done),
      .stall      (stall),
      .cache_hit  (cache_hit),
      .err        (err)
   );

   cache_array u_cache (
      .clk        (clk),
      .rst_n      (rst_n),
      .cache_cmd  (cache_cmd),
      .cache_stat (cache_stat)
   );

   // Slow main memory behind the cache
   banked_mem u_mem (
      .clk     (clk),
      .rst_n   (rst_n),
      .mem_cmd (mem_cmd),
      .mem_rsp (mem_rsp)
   );

endmodule

`default_nettype wire
